// ==== verilog/snake_params.svh ====
`ifndef SNAKE_PARAMS_SVH
`define SNAKE_PARAMS_SVH

// ##############################
// Grid and screen
// ##############################
`define SNAKE_GRID_W      40 // Border cells are walls.
`define SNAKE_GRID_H      30
`define SNAKE_CELL_SHIFT  4  // 16 pixel cells.
`define SNAKE_SCREEN_W    640
`define SNAKE_SCREEN_H    480

// ##############################
// Snake body and timing
// ##############################
`define SNAKE_MAX_SEGS    31
`define SNAKE_START_X     10 // Head cell after restart.
`define SNAKE_START_Y     5
`define SNAKE_START_LEN   3
`define SNAKE_STEP_CYCLES 12500000

`endif

// ==== verilog/snake_pkg.sv ====
`default_nettype none

package snake_pkg;

	typedef logic [5:0] coord_t; // Cell coordinate.
	typedef logic [9:0] pos_t; // Pixel coordinate.
	typedef logic [4:0] seg_count_t;

	typedef enum logic [1:0] {
		dir_up    = 2'd0,
		dir_down  = 2'd1,
		dir_left  = 2'd2,
		dir_right = 2'd3
	} dir_t;

	typedef enum logic [1:0] {
		cell_none = 2'd0,
		cell_head = 2'd1,
		cell_body = 2'd2,
		cell_wall = 2'd3
	} cell_kind_t;

	// Codes 1 and 4 to 7 run the step counter without moving the snake.
	typedef enum logic [2:0] {
		gs_restart = 3'd0,
		gs_play    = 3'd2,
		gs_wait    = 3'd3
	} game_status_t;

endpackage

`default_nettype wire

// ==== verilog/step_timer.sv ====
`default_nettype none

module step_timer #(
	parameter int step_cycles = 16
) (
	input  wire                      clk,
	input  wire                      rst,
	input  snake_pkg::game_status_t  game_status,
	output logic                     step
);
	import snake_pkg::*;

	localparam int cnt_w = (step_cycles > 1) ? $clog2(step_cycles) : 1;

	logic [cnt_w-1:0] cnt;
	logic             wrap;

	assign wrap = (cnt == cnt_w'(step_cycles - 1));
	assign step = wrap && (game_status == gs_play); // One cycle per period.

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cnt <= '0;
		end else if (game_status == gs_restart) begin
			cnt <= '0;
		end else if (game_status != gs_wait) begin
			if (wrap)
				cnt <= '0;
			else
				cnt <= cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/heading_ctrl.sv ====
`default_nettype none

module heading_ctrl (
	input  wire                      clk,
	input  wire                      rst,
	input  snake_pkg::game_status_t  game_status,
	input  wire                      left_press,
	input  wire                      right_press,
	input  wire                      up_press,
	input  wire                      down_press,
	output snake_pkg::dir_t          heading
);
	import snake_pkg::*;

	logic left_q;
	logic right_q;
	logic up_q;
	logic down_q;
	dir_t heading_next;

	// Only the highest priority key is captured; the rest keep their value.
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			left_q  <= 1'b0;
			right_q <= 1'b0;
			up_q    <= 1'b0;
			down_q  <= 1'b0;
		end else if (left_press) begin
			left_q <= 1'b1;
		end else if (right_press) begin
			right_q <= 1'b1;
		end else if (up_press) begin
			up_q <= 1'b1;
		end else if (down_press) begin
			down_q <= 1'b1;
		end else begin
			left_q  <= 1'b0; // Cleared once the keys are released.
			right_q <= 1'b0;
			up_q    <= 1'b0;
			down_q  <= 1'b0;
		end
	end

	always_comb begin
		heading_next = heading;
		case (heading)
			dir_up, dir_down: begin
				if (left_q)
					heading_next = dir_left;
				else if (right_q)
					heading_next = dir_right;
			end
			dir_left, dir_right: begin
				if (up_q)
					heading_next = dir_up;
				else if (down_q)
					heading_next = dir_down;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			heading <= dir_right;
		else if (game_status == gs_restart)
			heading <= dir_right;
		else if (game_status != gs_wait)
			heading <= heading_next;
	end

endmodule

`default_nettype wire

// ==== verilog/segment_count.sv ====
`default_nettype none

`include "snake_params.svh"

module segment_count (
	input  wire                      clk,
	input  wire                      rst,
	input  snake_pkg::game_status_t  game_status,
	input  wire                      add_cube,
	output snake_pkg::seg_count_t    cube_num
);
	import snake_pkg::*;

	logic armed; // High after an add_cube edge until add_cube falls.

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cube_num <= seg_count_t'(`SNAKE_START_LEN);
			armed    <= 1'b0;
		end else if (game_status == gs_restart) begin
			cube_num <= seg_count_t'(`SNAKE_START_LEN);
			armed    <= 1'b0;
		end else if (game_status != gs_wait) begin
			if (!armed) begin
				if (add_cube) begin
					armed <= 1'b1;
					if (cube_num != seg_count_t'(`SNAKE_MAX_SEGS))
						cube_num <= cube_num + 1'b1; // Saturates at capacity.
				end
			end else if (!add_cube) begin
				armed <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/collision_detect.sv ====
`default_nettype none

`include "snake_params.svh"

module collision_detect (
	input  snake_pkg::dir_t                              heading,
	input  snake_pkg::coord_t [`SNAKE_MAX_SEGS-1:0]      seg_x,
	input  snake_pkg::coord_t [`SNAKE_MAX_SEGS-1:0]      seg_y,
	input  snake_pkg::seg_count_t                        cube_num,
	output logic                                         wall_ahead,
	output logic                                         body_overlap
);
	import snake_pkg::*;

	// Head on the last free cell before the border, facing it.
	always_comb begin
		wall_ahead = 1'b0;
		case (heading)
			dir_up:    wall_ahead = (seg_y[0] == coord_t'(1));
			dir_down:  wall_ahead = (seg_y[0] == coord_t'(`SNAKE_GRID_H - 2));
			dir_left:  wall_ahead = (seg_x[0] == coord_t'(1));
			dir_right: wall_ahead = (seg_x[0] == coord_t'(`SNAKE_GRID_W - 2));
		endcase
	end

	always_comb begin
		body_overlap = 1'b0;
		for (int i = 1; i < `SNAKE_MAX_SEGS; i++) begin
			if ((i < int'(cube_num)) && (seg_x[i] == seg_x[0]) && (seg_y[i] == seg_y[0]))
				body_overlap = 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/body_shifter.sv ====
`default_nettype none

`include "snake_params.svh"

module body_shifter (
	input  wire                                          clk,
	input  wire                                          rst,
	input  snake_pkg::game_status_t                      game_status,
	input  wire                                          step,
	input  snake_pkg::dir_t                              heading,
	input  wire                                          wall_ahead,
	input  wire                                          body_overlap,
	output snake_pkg::coord_t [`SNAKE_MAX_SEGS-1:0]      seg_x,
	output snake_pkg::coord_t [`SNAKE_MAX_SEGS-1:0]      seg_y,
	output logic                                         hit_wall,
	output logic                                         hit_body
);
	import snake_pkg::*;

	coord_t next_x;
	coord_t next_y;

	function automatic coord_t start_x(int i);
		return (i < `SNAKE_START_LEN) ? coord_t'(`SNAKE_START_X - i) : '0;
	endfunction

	function automatic coord_t start_y(int i);
		return (i < `SNAKE_START_LEN) ? coord_t'(`SNAKE_START_Y) : '0;
	endfunction

	// Head cell after a move.
	always_comb begin
		next_x = seg_x[0];
		next_y = seg_y[0];
		case (heading)
			dir_up:    next_y = seg_y[0] - 1'b1;
			dir_down:  next_y = seg_y[0] + 1'b1;
			dir_left:  next_x = seg_x[0] - 1'b1;
			dir_right: next_x = seg_x[0] + 1'b1;
		endcase
	end

	// ##############################
	// Segment chain and hit flags
	// ##############################
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < `SNAKE_MAX_SEGS; i++) begin
				seg_x[i] <= start_x(i);
				seg_y[i] <= start_y(i);
			end
			hit_wall <= 1'b0;
			hit_body <= 1'b0;
		end else if (game_status == gs_restart) begin
			for (int i = 0; i < `SNAKE_MAX_SEGS; i++) begin
				seg_x[i] <= start_x(i);
				seg_y[i] <= start_y(i);
			end
			hit_wall <= 1'b0;
			hit_body <= 1'b0;
		end else if (step) begin // Step only pulses in play.
			if (wall_ahead) begin
				hit_wall <= 1'b1;
			end else if (body_overlap) begin
				hit_body <= 1'b1;
			end else begin
				seg_x <= {seg_x[`SNAKE_MAX_SEGS-2:0], next_x};
				seg_y <= {seg_y[`SNAKE_MAX_SEGS-2:0], next_y};
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/pixel_classifier.sv ====
`default_nettype none

`include "snake_params.svh"

module pixel_classifier (
	input  snake_pkg::pos_t                              x_pos,
	input  snake_pkg::pos_t                              y_pos,
	input  snake_pkg::coord_t [`SNAKE_MAX_SEGS-1:0]      seg_x,
	input  snake_pkg::coord_t [`SNAKE_MAX_SEGS-1:0]      seg_y,
	input  snake_pkg::seg_count_t                        cube_num,
	input  wire                                          die_flash,
	output snake_pkg::cell_kind_t                        pixel_kind
);
	import snake_pkg::*;

	coord_t cell_x;
	coord_t cell_y;
	logic   on_screen;
	logic   on_border;
	logic   on_head;
	logic   on_body;

	assign cell_x = x_pos[$bits(pos_t)-1:`SNAKE_CELL_SHIFT];
	assign cell_y = y_pos[$bits(pos_t)-1:`SNAKE_CELL_SHIFT];

	assign on_screen = (x_pos < pos_t'(`SNAKE_SCREEN_W)) && (y_pos < pos_t'(`SNAKE_SCREEN_H));
	assign on_border = (cell_x == '0) || (cell_x == coord_t'(`SNAKE_GRID_W - 1)) ||
		(cell_y == '0) || (cell_y == coord_t'(`SNAKE_GRID_H - 1));
	assign on_head = (cell_x == seg_x[0]) && (cell_y == seg_y[0]);

	always_comb begin
		on_body = 1'b0;
		for (int i = 1; i < `SNAKE_MAX_SEGS; i++) begin
			if ((i < int'(cube_num)) && (seg_x[i] == cell_x) && (seg_y[i] == cell_y))
				on_body = 1'b1;
		end
	end

	// die_flash low blanks the snake but keeps the walls.
	always_comb begin
		if (!on_screen)
			pixel_kind = cell_none;
		else if (on_border)
			pixel_kind = cell_wall;
		else if (on_head)
			pixel_kind = die_flash ? cell_head : cell_none;
		else if (on_body)
			pixel_kind = die_flash ? cell_body : cell_none;
		else
			pixel_kind = cell_none;
	end

endmodule

`default_nettype wire

// ==== verilog/snake_core.sv ====
`default_nettype none

`include "snake_params.svh"

module snake_core #(
	parameter int step_cycles = `SNAKE_STEP_CYCLES
) (
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      left_press,
	input  wire                      right_press,
	input  wire                      up_press,
	input  wire                      down_press,
	input  wire                      add_cube,
	input  wire                      die_flash,
	input  snake_pkg::game_status_t  game_status,
	input  snake_pkg::pos_t          x_pos,
	input  snake_pkg::pos_t          y_pos,
	output snake_pkg::cell_kind_t    pixel_kind,
	output snake_pkg::coord_t        head_x,
	output snake_pkg::coord_t        head_y,
	output snake_pkg::seg_count_t    cube_num,
	output logic                     hit_wall,
	output logic                     hit_body
);
	import snake_pkg::*;

	coord_t [`SNAKE_MAX_SEGS-1:0] seg_x;
	coord_t [`SNAKE_MAX_SEGS-1:0] seg_y;
	dir_t                         heading;
	logic                         step;
	logic                         wall_ahead;
	logic                         body_overlap;

	assign head_x = seg_x[0];
	assign head_y = seg_y[0];

	step_timer #(.step_cycles(step_cycles)) u_step_timer (
		.clk(clk), .rst(rst), .game_status(game_status), .step(step)
	);

	heading_ctrl u_heading_ctrl (
		.clk(clk), .rst(rst), .game_status(game_status),
		.left_press(left_press), .right_press(right_press),
		.up_press(up_press), .down_press(down_press), .heading(heading)
	);

	segment_count u_segment_count (
		.clk(clk), .rst(rst), .game_status(game_status),
		.add_cube(add_cube), .cube_num(cube_num)
	);

	collision_detect u_collision_detect (
		.heading(heading), .seg_x(seg_x), .seg_y(seg_y), .cube_num(cube_num),
		.wall_ahead(wall_ahead), .body_overlap(body_overlap)
	);

	body_shifter u_body_shifter (
		.clk(clk), .rst(rst), .game_status(game_status), .step(step),
		.heading(heading), .wall_ahead(wall_ahead), .body_overlap(body_overlap),
		.seg_x(seg_x), .seg_y(seg_y), .hit_wall(hit_wall), .hit_body(hit_body)
	);

	pixel_classifier u_pixel_classifier (
		.x_pos(x_pos), .y_pos(y_pos), .seg_x(seg_x), .seg_y(seg_y),
		.cube_num(cube_num), .die_flash(die_flash), .pixel_kind(pixel_kind)
	);

endmodule

`default_nettype wire

// ==== testbench/snake_chk.sv ====
`default_nettype none

module snake_chk (
	input  wire                      clk,
	input  wire                      rst,
	input  snake_pkg::game_status_t  game_status,
	input  snake_pkg::coord_t        head_x,
	input  snake_pkg::coord_t        head_y,
	input  snake_pkg::seg_count_t    cube_num,
	input  wire                      die_flash,
	input  snake_pkg::cell_kind_t    pixel_kind,
	input  wire                      hit_wall,
	input  wire                      hit_body
);
	import snake_pkg::*;

	function automatic logic near(coord_t a, coord_t b);
		return (a == b) || (a == b + 1'b1) || (b == a + 1'b1);
	endfunction

	// One axis moves by one cell. Restart may jump back to the start.
	head_step: assert property (@(posedge clk) disable iff (!rst)
		(game_status != gs_restart) |=>
		((head_x == $past(head_x)) && near(head_y, $past(head_y))) ||
		((head_y == $past(head_y)) && near(head_x, $past(head_x))))
		else $error("head moved more than one cell in a clock");

	// Growth adds at most one segment per clock and never wraps.
	len_max: assert property (@(posedge clk) disable iff (!rst)
		(game_status != gs_restart) |=>
		(cube_num == $past(cube_num)) || (int'(cube_num) == int'($past(cube_num)) + 1))
		else $error("cube_num grew by more than one or wrapped past capacity");

	dark_snake: assert property (@(posedge clk) disable iff (!rst)
		!die_flash |-> (pixel_kind != cell_head) && (pixel_kind != cell_body))
		else $error("snake drawn while die_flash is low");

	hits_clear: assert property (@(posedge clk) disable iff (!rst)
		(game_status == gs_restart) |=> (!hit_wall && !hit_body))
		else $error("hit flag still set after restart");

endmodule

bind snake_core snake_chk u_snake_chk (
	.clk(clk), .rst(rst), .game_status(game_status), .head_x(head_x), .head_y(head_y),
	.cube_num(cube_num), .die_flash(die_flash), .pixel_kind(pixel_kind),
	.hit_wall(hit_wall), .hit_body(hit_body)
);

`default_nettype wire

// ==== testbench/snake_tb.sv ====
`default_nettype none

module snake_tb;
	import snake_pkg::*;

	localparam int step_cycles = 16;
	localparam int max_tests = 64;

	logic         clk;
	logic         rst;
	logic         left_press;
	logic         right_press;
	logic         up_press;
	logic         down_press;
	logic         add_cube;
	logic         die_flash;
	game_status_t game_status;
	pos_t         x_pos;
	pos_t         y_pos;
	cell_kind_t   pixel_kind;
	coord_t       head_x;
	coord_t       head_y;
	seg_count_t   cube_num;
	logic         hit_wall;
	logic         hit_body;

	// Columns are arg, x_pos, y_pos and the expected head_x, head_y, cube_num, hits, kind.
	string test_name[max_tests];
	string test_cmd[max_tests];
	int    test_val[max_tests][8];
	int    num_tests;
	int    test_errors;
	int    pass_count;
	int    fail_count;

	snake_core #(.step_cycles(step_cycles)) u_snake_core (
		.clk(clk), .rst(rst), .left_press(left_press), .right_press(right_press),
		.up_press(up_press), .down_press(down_press), .add_cube(add_cube),
		.die_flash(die_flash), .game_status(game_status), .x_pos(x_pos), .y_pos(y_pos),
		.pixel_kind(pixel_kind), .head_x(head_x), .head_y(head_y), .cube_num(cube_num),
		.hit_wall(hit_wall), .hit_body(hit_body)
	);

	always #5 clk = ~clk;

	task automatic load_stimulus(output bit ok);
		int    fd;
		string line;
		string name;
		string cmd;
		int    v[8];
		num_tests = 0;
		fd = $fopen("testbench/snake_stimulus.txt", "r");
		ok = (fd != 0);
		while (ok && !$feof(fd) && num_tests < max_tests) begin
			if ($fgets(line, fd) != 0) begin
				// Comment lines stop scanning after two fields.
				if ($sscanf(line, "%s %s %d %d %d %d %d %d %d %d", name, cmd,
						v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]) == 10) begin
					test_name[num_tests] = name;
					test_cmd[num_tests]  = cmd;
					test_val[num_tests]  = v;
					num_tests++;
				end
			end
		end
		if (fd != 0)
			$fclose(fd);
		ok = ok && (num_tests > 0);
	endtask

	task automatic drive_key(int key);
		left_press  <= (key == 0);
		right_press <= (key == 1);
		up_press    <= (key == 2);
		down_press  <= (key == 3);
	endtask

	task automatic restart_game();
		@(posedge clk);
		game_status <= gs_restart;
		add_cube    <= 1'b0;
		drive_key(-1);
		repeat (2) @(posedge clk);
		game_status <= gs_wait;
	endtask

	// Plays whole step periods so the step counter rests on a period boundary.
	task automatic play_steps(int steps);
		@(posedge clk);
		game_status <= gs_play;
		repeat (2) @(posedge clk);
		drive_key(-1); // Heading has taken the key by now.
		repeat (steps * step_cycles - 2) @(posedge clk);
		game_status <= gs_wait;
	endtask

	task automatic pulse_add_cube(int pulses);
		@(posedge clk);
		game_status <= game_status_t'(3'd1); // Counter runs but the snake stays.
		repeat (pulses) begin
			add_cube <= 1'b1;
			repeat (step_cycles / 2) @(posedge clk);
			add_cube <= 1'b0;
			repeat (step_cycles / 2) @(posedge clk);
		end
		game_status <= gs_wait;
	endtask

	task automatic check_value(string what, int got, int exp);
		assert (got == exp) else begin
			$display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
			test_errors++;
		end
	endtask

	task automatic run_test(int t);
		int    v[8];
		string cmd;
		v           = test_val[t];
		cmd         = test_cmd[t];
		test_errors = 0;
		if (cmd == "restart")
			restart_game();
		else if (cmd == "play")
			play_steps(v[0]);
		else if (cmd == "grow")
			pulse_add_cube(v[0]);
		else if (cmd == "key") begin
			@(posedge clk);
			drive_key(v[0]); // Held until the next play or restart.
		end else if (cmd == "wait") begin
			@(posedge clk);
			game_status <= gs_wait;
			repeat (4 + $urandom % 40) @(posedge clk);
		end else if (cmd == "probe") begin
			@(posedge clk);
			die_flash <= v[0][0];
			x_pos     <= pos_t'(v[1]);
			y_pos     <= pos_t'(v[2]);
		end else begin
			$display("Unknown command %s in test %s", cmd, test_name[t]);
			test_errors++;
		end
		repeat (step_cycles / 2) @(posedge clk); // Half a period past the boundary.
		@(negedge clk);
		check_value("head_x", int'(head_x), v[3]);
		check_value("head_y", int'(head_y), v[4]);
		check_value("cube_num", int'(cube_num), v[5]);
		check_value("hit flags", int'({hit_body, hit_wall}), v[6]);
		if (cmd == "probe")
			check_value("pixel_kind", int'(pixel_kind), v[7]);
		if (test_errors == 0) begin
			$display("%-16s ok", test_name[t]);
			pass_count++;
		end else begin
			$display("%-16s FAILED with %0d errors", test_name[t], test_errors);
			fail_count++;
		end
	endtask

	task automatic watchdog(longint limit);
		#(limit);
		$display("Timeout: the run did not end within %0d time units", limit);
		$display("test failed");
		$finish;
	endtask

	initial begin
		bit     ok;
		longint cycles;
		void'($urandom(32'h4412ed8f));
		clk         = 1'b0;
		rst         = 1'b0;
		left_press  = 1'b0;
		right_press = 1'b0;
		up_press    = 1'b0;
		down_press  = 1'b0;
		add_cube    = 1'b0;
		die_flash   = 1'b1;
		game_status = gs_wait;
		x_pos       = '0;
		y_pos       = '0;
		pass_count  = 0;
		fail_count  = 0;
		load_stimulus(ok);
		if (!ok) begin
			$display("Stimulus file testbench/snake_stimulus.txt is missing or empty");
			fail_count = 1;
		end else begin
			cycles = 0;
			for (int t = 0; t < num_tests; t++) begin
				cycles += 64;
				if (test_cmd[t] == "play" || test_cmd[t] == "grow")
					cycles += test_val[t][0] * step_cycles;
			end
			fork
				watchdog(cycles * 10 + 1000);
			join_none
			repeat (4) @(posedge clk);
			rst <= 1'b1;
			for (int t = 0; t < num_tests; t++)
				run_test(t);
		end
		$display("%0d tests, %0d passed, %0d failed", num_tests, pass_count, fail_count);
		if (fail_count == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/snake_stimulus.txt ====
# name cmd arg x_pos y_pos | expected head_x head_y cube_num hits kind
# arg: steps, pulses, key (0 left 1 right 2 up 3 down) or die_flash; hits = body*2 + wall
start restart 0 0 0 10 5 3 0 0
move_right play 3 0 0 13 5 3 0 0
press_up key 2 0 0 13 5 3 0 0
move_up play 2 0 0 13 3 3 0 0
press_down key 3 0 0 13 3 3 0 0
no_reverse play 1 0 0 13 2 3 0 0
frozen wait 0 0 0 13 2 3 0 0
probe_wall probe 1 0 100 13 2 3 0 3
probe_head probe 1 216 40 13 2 3 0 1
probe_head_dark probe 0 216 40 13 2 3 0 0
probe_body probe 1 216 56 13 2 3 0 2
probe_empty probe 1 328 328 13 2 3 0 0
probe_offscreen probe 1 700 10 13 2 3 0 0
grow_one grow 1 0 0 13 2 4 0 0
grow_saturate grow 30 0 0 13 2 31 0 0
restart_wall restart 0 0 0 10 5 3 0 0
to_wall play 28 0 0 38 5 3 0 0
hit_wall play 1 0 0 38 5 3 1 0
clear_wall restart 0 0 0 10 5 3 0 0
run_on play 4 0 0 14 5 3 0 0
grow_two grow 2 0 0 14 5 5 0 0
turn_up key 2 0 0 14 5 5 0 0
go_up play 1 0 0 14 4 5 0 0
turn_left key 0 0 0 14 4 5 0 0
go_left play 1 0 0 13 4 5 0 0
turn_down key 3 0 0 13 4 5 0 0
go_down play 1 0 0 13 5 5 0 0
bite play 1 0 0 13 5 5 2 0

// ==== project.f ====
+incdir+verilog
verilog/snake_pkg.sv
verilog/step_timer.sv
verilog/heading_ctrl.sv
verilog/segment_count.sv
verilog/collision_detect.sv
verilog/body_shifter.sv
verilog/pixel_classifier.sv
verilog/snake_core.sv
testbench/snake_chk.sv
testbench/snake_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the snake testbench with Verilator, runs it and scans the log.
set -u

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module snake_tb -f project.f -o snake_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/snake_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "test failed" "$log"; then
	exit 1
fi
exit 0
